//--- source/quant_pkg.sv
package quant_pkg;

  ////////////////////
  // precision modes
  ////////////////////

  // wide uses the lower lanes only, dual splits the lanes into two channels
  typedef enum logic [0:0] {
    quant_mode_wide = 1'b0,
    quant_mode_dual = 1'b1
  } quant_mode_e;

  ////////////////////
  // sizes
  ////////////////////

  // output channels per vector
  localparam int num_channels = 2;

  // quantized lane, unsigned after relu
  localparam int quant_width = 8;
  localparam int quant_max   = 255;

  // per-channel signed bias
  localparam int bias_width = 8;

  // per-channel right shift amount
  localparam int shift_width = 8;

  // shifts at or beyond this give zero
  localparam int shift_limit = 32;

endpackage

//--- source/bias_adder.sv
`timescale 1ns/1ps

module bias_adder
  import quant_pkg::*;
#(
  parameter int  num_columns       = 4,
  parameter int  pixels_per_column = 2,
  parameter int  acc_width         = 24,
  localparam int lane_count        = num_columns * pixels_per_column * num_channels,
  localparam int sum_width         = acc_width + 8
) (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                acc_valid,
  input  logic [lane_count*acc_width-1:0]     acc_vector,
  input  logic [num_channels*bias_width-1:0]  bias_set,
  input  logic [num_channels*shift_width-1:0] scale_set,
  input  quant_mode_e                         mode,
  output logic                                sum_valid,
  output logic [lane_count*sum_width-1:0]     sum_vector,
  output quant_mode_e                         sum_mode,
  output logic [num_channels*shift_width-1:0] sum_scale_set
);

  localparam int half_lanes = lane_count / 2;

  logic [lane_count*sum_width-1:0] sum_next;

  ////////////////////
  // per-lane bias add
  ////////////////////

  for (genvar i = 0; i < lane_count; i++) begin : g_lane
    // lower half is channel 0, upper half channel 1
    localparam int lane_ch = (i < half_lanes) ? 0 : 1;

    logic signed [sum_width-1:0] acc_ext;
    logic signed [sum_width-1:0] bias_ext;

    always_comb begin
      acc_ext = $signed(acc_vector[i*acc_width +: acc_width]);
      // wide mode has a single channel, so every lane takes bias 0
      if (mode == quant_mode_dual) begin
        bias_ext = $signed(bias_set[lane_ch*bias_width +: bias_width]);
      end else begin
        bias_ext = $signed(bias_set[bias_width-1:0]);
      end
    end

    // eight bits of headroom, cannot wrap
    assign sum_next[i*sum_width +: sum_width] = acc_ext + bias_ext;
  end

  ////////////////////
  // output register
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sum_valid <= 1'b0;
    end else begin
      sum_valid <= acc_valid;
    end
  end

  // mode and shifts ride along so the inputs may change next cycle
  always_ff @(posedge clk) begin
    if (acc_valid) begin
      sum_vector    <= sum_next;
      sum_mode      <= mode;
      sum_scale_set <= scale_set;
    end
  end

  a_mode_legal : assert property (
    @(posedge clk) disable iff (!rst_n)
    acc_valid |-> (!$isunknown(mode) && (mode inside {quant_mode_wide, quant_mode_dual}))
  ) else $error("bias_adder: mode not legal while acc_valid is high");

endmodule

//--- source/relu_scale_quant.sv
`timescale 1ns/1ps

module relu_scale_quant
  import quant_pkg::*;
#(
  parameter int  num_columns       = 4,
  parameter int  pixels_per_column = 2,
  parameter int  acc_width         = 24,
  localparam int lane_count        = num_columns * pixels_per_column * num_channels,
  localparam int sum_width         = acc_width + 8
) (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                sum_valid,
  input  logic [lane_count*sum_width-1:0]     sum_vector,
  input  quant_mode_e                         sum_mode,
  input  logic [num_channels*shift_width-1:0] sum_scale_set,
  output logic                                quant_valid,
  output logic [lane_count*quant_width-1:0]   quant_vector,
  output quant_mode_e                         quant_mode
);

  localparam int half_lanes = lane_count / 2;

  logic [lane_count*quant_width-1:0] quant_next;

  ////////////////////
  // per-lane requant
  ////////////////////

  for (genvar i = 0; i < lane_count; i++) begin : g_lane
    localparam int lane_ch = (i < half_lanes) ? 0 : 1;

    logic [sum_width-1:0]   sum_val;
    logic [shift_width-1:0] shift;
    logic [sum_width-1:0]   shifted;
    logic [quant_width-1:0] lane_q;

    always_comb begin
      sum_val = sum_vector[i*sum_width +: sum_width];

      // channel 0 shift covers all lanes in wide mode
      if (sum_mode == quant_mode_dual) begin
        shift = sum_scale_set[lane_ch*shift_width +: shift_width];
      end else begin
        shift = sum_scale_set[shift_width-1:0];
      end

      // logical shift, sign already known to be clear when it is used
      shifted = sum_val >> shift;

      if ((sum_mode == quant_mode_wide) && (lane_ch == 1)) begin
        // upper half unused in wide mode
        lane_q = '0;
      end else if (sum_val[sum_width-1]) begin
        // relu
        lane_q = '0;
      end else if (shift >= shift_limit) begin
        lane_q = '0;
      end else if (shifted > quant_max) begin
        // saturate
        lane_q = quant_width'(quant_max);
      end else begin
        lane_q = shifted[quant_width-1:0];
      end
    end

    assign quant_next[i*quant_width +: quant_width] = lane_q;
  end

  ////////////////////
  // output register
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      quant_valid <= 1'b0;
    end else begin
      quant_valid <= sum_valid;
    end
  end

  // holds the last result between strobes
  always_ff @(posedge clk) begin
    if (sum_valid) begin
      quant_vector <= quant_next;
      quant_mode   <= sum_mode;
    end
  end

  a_valid_follows : assert property (
    @(posedge clk) disable iff (!rst_n)
    sum_valid |=> quant_valid
  ) else $error("relu_scale_quant: quant_valid missing one cycle after sum_valid");

  a_no_extra_valid : assert property (
    @(posedge clk) disable iff (!rst_n)
    !sum_valid |=> !quant_valid
  ) else $error("relu_scale_quant: quant_valid without a sum_valid before it");

endmodule

//--- source/quant_out_packer.sv
`timescale 1ns/1ps

module quant_out_packer
  import quant_pkg::*;
#(
  parameter int  num_columns       = 4,
  parameter int  pixels_per_column = 2,
  parameter int  lanes_per_beat    = 4,
  localparam int lane_count        = num_columns * pixels_per_column * num_channels
) (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  quant_valid,
  input  logic [lane_count*quant_width-1:0]     quant_vector,
  input  quant_mode_e                           quant_mode,
  output logic                                  out_valid,
  output logic [lanes_per_beat*quant_width-1:0] out_word,
  output logic                                  out_last,
  output logic                                  overflow
);

  localparam int vec_width  = lane_count * quant_width;
  localparam int word_width = lanes_per_beat * quant_width;
  localparam int beats_dual = lane_count / lanes_per_beat;
  // wide mode only sends the lower half
  localparam int beats_wide = beats_dual / 2;
  localparam int cnt_width  = (beats_dual > 1) ? $clog2(beats_dual) : 1;

  // slot 0 is the head, slot 1 the waiting vector
  logic [vec_width-1:0] slot_vec  [2];
  quant_mode_e          slot_mode [2];
  logic [1:0]           count;
  logic [cnt_width-1:0] beat_cnt;
  logic [cnt_width-1:0] last_beat;
  logic                 push;
  logic                 pop;

  ////////////////////
  // beat output
  ////////////////////

  assign last_beat = (slot_mode[0] == quant_mode_dual) ? cnt_width'(beats_dual - 1)
                                                       : cnt_width'(beats_wide - 1);

  assign out_valid = (count != 2'd0);
  assign out_last  = out_valid && (beat_cnt == last_beat);
  assign out_word  = slot_vec[0][beat_cnt*word_width +: word_width];

  // head leaves on its last beat; an arrival at a full queue is lost
  assign pop  = out_last;
  assign push = quant_valid && (count != 2'd2);

  ////////////////////
  // queue control
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count    <= 2'd0;
      beat_cnt <= '0;
      overflow <= 1'b0;
    end else begin
      if (push && !pop) begin
        count <= count + 2'd1;
      end else if (pop && !push) begin
        count <= count - 2'd1;
      end

      // next vector starts right after out_last
      if (pop) begin
        beat_cnt <= '0;
      end else if (out_valid) begin
        beat_cnt <= beat_cnt + 1'b1;
      end

      // sticky until reset
      if (quant_valid && !push) begin
        overflow <= 1'b1;
      end
    end
  end

  // slot payload
  always_ff @(posedge clk) begin
    if (pop) begin
      slot_vec[0]  <= slot_vec[1];
      slot_mode[0] <= slot_mode[1];
    end
    // with a pop the new vector lands in the freed head slot
    if (push) begin
      if ((count == 2'd0) || pop) begin
        slot_vec[0]  <= quant_vector;
        slot_mode[0] <= quant_mode;
      end else begin
        slot_vec[1]  <= quant_vector;
        slot_mode[1] <= quant_mode;
      end
    end
  end

  a_last_needs_valid : assert property (
    @(posedge clk) disable iff (!rst_n)
    out_last |-> out_valid
  ) else $error("quant_out_packer: out_last without out_valid");

  a_count_bound : assert property (
    @(posedge clk) disable iff (!rst_n)
    count <= 2'd2
  ) else $error("quant_out_packer: queue count above two");

endmodule

//--- source/quant_out_stage.sv
`timescale 1ns/1ps

module quant_out_stage
  import quant_pkg::*;
#(
  parameter int  num_columns       = 4,
  parameter int  pixels_per_column = 2,
  parameter int  acc_width         = 24,
  parameter int  lanes_per_beat    = 4,
  localparam int lane_count        = num_columns * pixels_per_column * num_channels,
  localparam int sum_width         = acc_width + 8
) (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  acc_valid,
  input  logic [lane_count*acc_width-1:0]       acc_vector,
  input  logic [num_channels*bias_width-1:0]    bias_set,
  input  logic [num_channels*shift_width-1:0]   scale_set,
  input  quant_mode_e                           mode,
  output logic                                  out_valid,
  output logic [lanes_per_beat*quant_width-1:0] out_word,
  output logic                                  out_last,
  output logic                                  overflow
);

  ////////////////////
  // stage wires
  ////////////////////

  // bias adder to requantizer
  logic                                sum_valid;
  logic [lane_count*sum_width-1:0]     sum_vector;
  quant_mode_e                         sum_mode;
  logic [num_channels*shift_width-1:0] sum_scale_set;

  // requantizer to packer
  logic                                quant_valid;
  logic [lane_count*quant_width-1:0]   quant_vector;
  quant_mode_e                         quant_mode;

  bias_adder #(
    .num_columns      (num_columns),
    .pixels_per_column(pixels_per_column),
    .acc_width        (acc_width)
  ) u_bias_adder (
    .clk          (clk),
    .rst_n        (rst_n),
    .acc_valid    (acc_valid),
    .acc_vector   (acc_vector),
    .bias_set     (bias_set),
    .scale_set    (scale_set),
    .mode         (mode),
    .sum_valid    (sum_valid),
    .sum_vector   (sum_vector),
    .sum_mode     (sum_mode),
    .sum_scale_set(sum_scale_set)
  );

  relu_scale_quant #(
    .num_columns      (num_columns),
    .pixels_per_column(pixels_per_column),
    .acc_width        (acc_width)
  ) u_relu_scale_quant (
    .clk          (clk),
    .rst_n        (rst_n),
    .sum_valid    (sum_valid),
    .sum_vector   (sum_vector),
    .sum_mode     (sum_mode),
    .sum_scale_set(sum_scale_set),
    .quant_valid  (quant_valid),
    .quant_vector (quant_vector),
    .quant_mode   (quant_mode)
  );

  quant_out_packer #(
    .num_columns      (num_columns),
    .pixels_per_column(pixels_per_column),
    .lanes_per_beat   (lanes_per_beat)
  ) u_quant_out_packer (
    .clk         (clk),
    .rst_n       (rst_n),
    .quant_valid (quant_valid),
    .quant_vector(quant_vector),
    .quant_mode  (quant_mode),
    .out_valid   (out_valid),
    .out_word    (out_word),
    .out_last    (out_last),
    .overflow    (overflow)
  );

endmodule

//--- tb/tb_quant_out_stage.sv
`timescale 1ns/1ps

module tb_quant_out_stage
  import quant_pkg::*;
();

  localparam int num_columns       = 4;
  localparam int pixels_per_column = 2;
  localparam int acc_width         = 24;
  localparam int lanes_per_beat    = 4;
  localparam int lane_count        = num_columns * pixels_per_column * num_channels;
  localparam int acc_bits          = lane_count * acc_width;
  localparam int word_bits         = lanes_per_beat * quant_width;
  localparam int never             = 32'h7fffffff;

  logic                                  clk;
  logic                                  rst_n;
  logic                                  acc_valid;
  logic [acc_bits-1:0]                   acc_vector;
  logic [num_channels*bias_width-1:0]    bias_set;
  logic [num_channels*shift_width-1:0]   scale_set;
  quant_mode_e                           mode;
  logic                                  out_valid;
  logic [word_bits-1:0]                  out_word;
  logic                                  out_last;
  logic                                  overflow;

  integer seed = 32'h1487;
  int     errors = 0;
  int     cyc = 0;

  // expected beats that the model writes and the monitor consumes
  logic [word_bits-1:0] exp_word_mem [256];
  logic                 exp_last_mem [256];
  int                   exp_cyc_mem  [256];
  int                   wr_ptr = 0;
  int                   rd_ptr = 0;
  logic                 exp_avail;
  logic [word_bits-1:0] exp_word;
  logic                 exp_last;
  int                   exp_cyc;

  // packer occupancy model
  int vec_push_cyc [64];
  int vec_last_cyc [64];
  int vec_count = 0;
  int last_end = -100;
  int ovf_cycle = never;

  assign exp_avail = (rd_ptr != wr_ptr);
  assign exp_word  = exp_word_mem[rd_ptr];
  assign exp_last  = exp_last_mem[rd_ptr];
  assign exp_cyc   = exp_cyc_mem[rd_ptr];

  quant_out_stage #(
    .num_columns      (num_columns),
    .pixels_per_column(pixels_per_column),
    .acc_width        (acc_width),
    .lanes_per_beat   (lanes_per_beat)
  ) u_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .acc_valid (acc_valid),
    .acc_vector(acc_vector),
    .bias_set  (bias_set),
    .scale_set (scale_set),
    .mode      (mode),
    .out_valid (out_valid),
    .out_word  (out_word),
    .out_last  (out_last),
    .overflow  (overflow)
  );

  always #5 clk = ~clk;

  // cycle count and beat consumption
  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (rst_n && out_valid && exp_avail) begin
      rd_ptr <= rd_ptr + 1;
    end
  end

  ////////////////////
  // checks
  ////////////////////

  a_reset_quiet : assert property (
    @(posedge clk) !rst_n |-> (!out_valid && !out_last && !overflow)
  ) else begin
    errors++;
    $display("output active while reset is asserted");
  end

  a_last_alone : assert property (
    @(posedge clk) disable iff (!rst_n) out_last |-> out_valid
  ) else begin
    errors++;
    $display("out_last high without out_valid at cycle %0d", $sampled(cyc));
  end

  a_beat_expected : assert property (
    @(posedge clk) disable iff (!rst_n) out_valid |-> exp_avail
  ) else begin
    errors++;
    $display("out_valid high with no beat expected at cycle %0d", $sampled(cyc));
  end

  a_beat_data : assert property (
    @(posedge clk) disable iff (!rst_n) (out_valid && exp_avail) |-> (out_word == exp_word)
  ) else begin
    errors++;
    $display("mismatch out_word expected %h actual %h", $sampled(exp_word), $sampled(out_word));
  end

  a_beat_last : assert property (
    @(posedge clk) disable iff (!rst_n) (out_valid && exp_avail) |-> (out_last == exp_last)
  ) else begin
    errors++;
    $display("mismatch out_last expected %h actual %h", $sampled(exp_last), $sampled(out_last));
  end

  a_beat_time : assert property (
    @(posedge clk) disable iff (!rst_n) (out_valid && exp_avail) |-> (cyc == exp_cyc)
  ) else begin
    errors++;
    $display("beat came at cycle %0d but was due at cycle %0d", $sampled(cyc), $sampled(exp_cyc));
  end

  a_beat_present : assert property (
    @(posedge clk) disable iff (!rst_n) (exp_avail && (cyc == exp_cyc)) |-> out_valid
  ) else begin
    errors++;
    $display("expected beat did not appear at cycle %0d", $sampled(cyc));
  end

  a_overflow : assert property (
    @(posedge clk) disable iff (!rst_n) overflow == (cyc >= ovf_cycle)
  ) else begin
    errors++;
    $display("mismatch overflow expected %h actual %h", $sampled(cyc >= ovf_cycle),
             $sampled(overflow));
  end

  ////////////////////
  // reference model
  ////////////////////

  function automatic logic [7:0] requant(input longint sum, input int shift);
    longint scaled;
    if (sum < 0) return 8'd0;
    if (shift >= 32) return 8'd0;
    scaled = sum >> shift;
    if (scaled > 255) return 8'd255;
    return scaled[7:0];
  endfunction

  // the packer takes the strobe three edges after drive_cyc
  task automatic model_vector(input quant_mode_e m, input logic [15:0] bias,
                              input logic [15:0] scale, input logic [acc_bits-1:0] acc,
                              input int drive_cyc);
    logic [7:0] q [lane_count];
    int         push_cyc;
    int         held;
    int         start;
    int         beats;
    int         ch;
    longint     sum;
    push_cyc = drive_cyc + 3;
    held = 0;
    for (int v = 0; v < vec_count; v++) begin
      if (vec_push_cyc[v] < push_cyc && vec_last_cyc[v] >= push_cyc) begin
        held++;
      end
    end
    if (held >= 2) begin
      // both slots taken so the vector is lost
      if (ovf_cycle == never) begin
        ovf_cycle = push_cyc + 1;
      end
      return;
    end
    for (int i = 0; i < lane_count; i++) begin
      ch = (m == quant_mode_dual && i >= lane_count / 2) ? 1 : 0;
      sum = longint'($signed(acc[i*acc_width +: acc_width])) + longint'($signed(bias[ch*8 +: 8]));
      if (m == quant_mode_wide && i >= lane_count / 2) begin
        q[i] = 8'd0;
      end else begin
        q[i] = requant(sum, int'(scale[ch*8 +: 8]));
      end
    end
    beats = (m == quant_mode_dual) ? 4 : 2;
    start = (push_cyc + 1 > last_end + 1) ? push_cyc + 1 : last_end + 1;
    for (int b = 0; b < beats; b++) begin
      exp_word_mem[wr_ptr] = {q[4*b+3], q[4*b+2], q[4*b+1], q[4*b]};
      exp_last_mem[wr_ptr] = (b == beats - 1);
      exp_cyc_mem[wr_ptr]  = start + b;
      wr_ptr++;
    end
    last_end = start + beats - 1;
    vec_push_cyc[vec_count] = push_cyc;
    vec_last_cyc[vec_count] = last_end;
    vec_count++;
  endtask

  ////////////////////
  // stimulus helpers
  ////////////////////

  function automatic logic [acc_bits-1:0] random_acc();
    logic [acc_bits-1:0] acc;
    for (int i = 0; i < lane_count; i++) begin
      acc[i*acc_width +: acc_width] = acc_width'($random(seed));
    end
    return acc;
  endfunction

  // shifts that keep most results between 0 and 255
  function automatic logic [15:0] random_scale();
    logic [7:0] s0;
    logic [7:0] s1;
    s0 = 8'd14 + 8'($random(seed) & 7);
    s1 = 8'd14 + 8'($random(seed) & 7);
    return {s1, s0};
  endfunction

  task automatic send_vector(input quant_mode_e m, input logic [15:0] bias,
                             input logic [15:0] scale, input logic [acc_bits-1:0] acc);
    @(posedge clk);
    acc_valid  <= 1'b1;
    acc_vector <= acc;
    bias_set   <= bias;
    scale_set  <= scale;
    mode       <= m;
    model_vector(m, bias, scale, acc, cyc);
  endtask

  // junk on the levels while idle so the DUT has to use its staged copies
  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      acc_valid <= 1'b0;
      bias_set  <= 16'($random(seed));
      scale_set <= 16'($random(seed));
    end
  endtask

  task automatic wait_for_beats(input int limit);
    int n;
    n = 0;
    while (rd_ptr != wr_ptr && n < limit) begin
      @(posedge clk);
      n++;
    end
    if (rd_ptr != wr_ptr) begin
      errors++;
      $display("timeout while waiting for out_valid beats");
    end
  endtask

  ////////////////////
  // main sequence
  ////////////////////

  initial begin
    logic [acc_bits-1:0] acc;
    clk        = 1'b0;
    rst_n      = 1'b0;
    acc_valid  = 1'b0;
    acc_vector = '0;
    bias_set   = '0;
    scale_set  = '0;
    mode       = quant_mode_dual;
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    idle(6);

    // dual mode with spaced strobes
    repeat (4) begin
      send_vector(quant_mode_dual, 16'($random(seed)), random_scale(), random_acc());
      idle(7);
    end
    wait_for_beats(40);

    // relu, saturation, zero shift and oversized shift
    acc = random_acc();
    acc[0*acc_width +: acc_width] = -24'sd5;
    acc[1*acc_width +: acc_width] = 24'sd2;
    acc[2*acc_width +: acc_width] = 24'sd252;
    acc[3*acc_width +: acc_width] = 24'sd253;
    acc[4*acc_width +: acc_width] = 24'sd100;
    acc[5*acc_width +: acc_width] = 24'sd8000000;
    for (int i = lane_count / 2; i < lane_count; i++) begin
      acc[i*acc_width +: acc_width] = 24'h400000 + i;
    end
    send_vector(quant_mode_dual, {8'hf9, 8'h03}, {8'd40, 8'd0}, acc);
    idle(7);
    wait_for_beats(40);

    // wide mode
    repeat (2) begin
      send_vector(quant_mode_wide, 16'($random(seed)), random_scale(), random_acc());
      idle(7);
    end
    wait_for_beats(40);

    // back to back with new mode and shifts
    send_vector(quant_mode_dual, 16'($random(seed)), random_scale(), random_acc());
    send_vector(quant_mode_wide, 16'($random(seed)), {8'd3, 8'd18}, random_acc());
    idle(2);
    wait_for_beats(40);
    idle(4);

    // third vector finds both slots full
    repeat (3) begin
      send_vector(quant_mode_dual, 16'($random(seed)), random_scale(), random_acc());
    end
    idle(2);
    wait_for_beats(40);
    idle(6);

    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- filelist.f
source/quant_pkg.sv
source/bias_adder.sv
source/relu_scale_quant.sv
source/quant_out_packer.sv
source/quant_out_stage.sv
tb/tb_quant_out_stage.sv
